// File: flist.f
src/aprPkg.sv
src/aprCmdDecode.sv
src/aprFlagCell.sv
src/aprStatusUnit.sv
src/fmAdrSelect.sv
src/aprTop.sv
sim/aprTop_sva.sv
sim/aprChecker.sv
sim/aprTb.sv

// File: run.sh
#!/bin/sh
# Build and run the APR testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/10ps \
  -Mdir obj_dir --top-module aprTb -f flist.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/VaprTb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "RESULT: PASS" sim.log; then
  exit 0
fi
echo "Pass line not found in sim.log"
exit 1

// File: sim/aprTb.sv
`timescale 1ns/10ps
`default_nettype none

module aprTb;

  localparam logic [3:0] OpIdle    = 4'd0;
  localparam logic [3:0] OpCono    = 4'd1;
  localparam logic [3:0] OpConi    = 4'd2;
  localparam logic [3:0] OpDatai   = 4'd3;
  localparam logic [3:0] OpSweep   = 4'd4;
  localparam logic [3:0] OpLoadBlk = 4'd5;
  localparam logic [3:0] OpLoadVma = 4'd6;
  localparam logic [3:0] OpPi      = 4'd7;
  localparam logic [3:0] OpFm      = 4'd8;
  localparam int ReadTimeout = 16;

  // CONO control bits
  localparam aprPkg::aprWord CClr     = 24'h1 << aprPkg::SelClrBit;
  localparam aprPkg::aprWord CSet     = 24'h1 << aprPkg::SelSetBit;
  localparam aprPkg::aprWord CDis     = 24'h1 << aprPkg::SelDisBit;
  localparam aprPkg::aprWord CEn      = 24'h1 << aprPkg::SelEnBit;
  localparam aprPkg::aprWord CLoadPia = 24'h1 << aprPkg::LoadPiaBit;
  // Bit 3 of fast-memory step data drives xrPrevious
  localparam aprPkg::aprWord XrPrev   = 24'h8;

  typedef struct packed {
    logic [3:0]     op;
    aprPkg::aprWord data;
    logic [6:0]     evts;
    aprPkg::aprWord expWord;
  } stepEntry;

  logic           clk;
  logic           rstN;
  logic           conoApr;
  logic           coniApr;
  logic           dataiApr;
  logic           loadAcBlocks;
  aprPkg::aprWord ebusData;
  logic [6:0]     errEvent;
  logic           sweepBusy;
  aprPkg::acAdr   ac;
  aprPkg::acAdr   xr;
  aprPkg::acAdr   vmaAdr;
  aprPkg::acAdr   magic;
  aprPkg::acBlock magicBlock;
  aprPkg::fmSel   fmAdrSel;
  logic           xrPrevious;
  logic           vmaPrevEn;
  logic           loadVmaContext;
  logic           aprInt;
  logic           aprPiReq;
  aprPkg::piLevel aprPia;
  aprPkg::aprWord readData;
  logic           readValid;
  aprPkg::acAdr   fmAdr;
  aprPkg::acBlock fmBlock;
  logic           chkRead;
  logic           chkPi;
  logic           chkFm;
  aprPkg::aprWord expValue;
  logic           runDone;
  int             passCount;
  int             failCount;
  logic           timedOut;
  stepEntry       steps[$];

  aprTop DUT (.*);

  aprChecker uChecker (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic aprPkg::aprWord piaField(input aprPkg::piLevel pia);
    aprPkg::aprWord w;
    w = CLoadPia;
    w[aprPkg::PiaLsb +: 3] = pia;
    return w;
  endfunction

  function automatic aprPkg::aprWord coniExp(input aprPkg::flagVec f, input aprPkg::flagVec e,
                                             input aprPkg::piLevel p, input logic intr);
    aprPkg::aprWord w;
    w = '0;
    w[aprPkg::ConiFlagLsb +: 8] = f;
    w[aprPkg::ConiEnLsb +: 8] = e;
    w[aprPkg::ConiPiaLsb +: 3] = p;
    w[aprPkg::ConiIntBit] = intr;
    return w;
  endfunction

  task automatic addStep(input logic [3:0] op, input aprPkg::aprWord data,
                         input logic [6:0] evts, input aprPkg::aprWord expWord);
    steps.push_back('{op, data, evts, expWord});
  endtask

  task automatic buildTable();
    // Reset state
    addStep(OpConi, '0, '0, coniExp(8'h00, 8'h00, 3'd0, 1'b0));
    addStep(OpPi, '0, '0, 24'h0);
    addStep(OpDatai, '0, '0, 24'h0);
    // Set and clear by mask
    addStep(OpCono, CSet | 24'h2d, '0, '0);
    addStep(OpConi, '0, '0, coniExp(8'h2d, 8'h00, 3'd0, 1'b0));
    addStep(OpCono, CClr | 24'h0c, '0, '0);
    addStep(OpConi, '0, '0, coniExp(8'h21, 8'h00, 3'd0, 1'b0));
    addStep(OpCono, CClr | 24'h21, '0, '0);
    addStep(OpConi, '0, '0, coniExp(8'h00, 8'h00, 3'd0, 1'b0));
    // Error pulses, then an event against a clear of the same flag
    addStep(OpIdle, '0, 7'h06, '0);
    addStep(OpConi, '0, '0, coniExp(8'h06, 8'h00, 3'd0, 1'b0));
    addStep(OpCono, CClr | 24'h06, 7'h02, '0);
    addStep(OpConi, '0, '0, coniExp(8'h02, 8'h00, 3'd0, 1'b0));
    // Pi steps expect {aprInt, aprPiReq, aprPia}
    addStep(OpCono, CEn | piaField(3'd5) | 24'h02, '0, '0);
    addStep(OpPi, '0, '0, 24'h1d);
    addStep(OpConi, '0, '0, coniExp(8'h02, 8'h02, 3'd5, 1'b1));
    addStep(OpCono, CDis | 24'h02, '0, '0);
    addStep(OpPi, '0, '0, 24'h05);
    addStep(OpCono, CEn | 24'h02, '0, '0);
    addStep(OpPi, '0, '0, 24'h1d);
    addStep(OpCono, piaField(3'd0), '0, '0);
    addStep(OpPi, '0, '0, 24'h10);
    addStep(OpConi, '0, '0, coniExp(8'h02, 8'h02, 3'd0, 1'b1));
    addStep(OpCono, CClr | CDis | 24'hff, '0, '0);
    // Sweep done on the falling edge only
    addStep(OpSweep, 24'h1, '0, '0);
    addStep(OpConi, '0, '0, coniExp(8'h00, 8'h00, 3'd0, 1'b0));
    addStep(OpSweep, 24'h0, '0, '0);
    addStep(OpConi, '0, '0, coniExp(8'h80, 8'h00, 3'd0, 1'b0));
    // Previous block 6, current 3, then VMA block from previous
    addStep(OpLoadBlk, 24'h33, '0, '0);
    addStep(OpLoadVma, 24'h1, '0, '0);
    // Fm steps expect {fmBlock, fmAdr} with ac 15, xr 9, vmaAdr 5, magic 10 in block 2
    addStep(OpFm, 24'(aprPkg::FmAcPlus1), '0, 24'h30);
    addStep(OpFm, XrPrev | 24'(aprPkg::FmXr), '0, 24'h69);
    addStep(OpFm, 24'(aprPkg::FmVma), '0, 24'h65);
    addStep(OpFm, 24'(aprPkg::FmAcPlusMagic), '0, 24'h39);
    addStep(OpFm, 24'(aprPkg::FmMagic), '0, 24'h2a);
    addStep(OpDatai, '0, '0, 24'h0001b3);
  endtask

  task automatic applyStep(input stepEntry s);
    int waited;
    waited = 0;
    errEvent = s.evts;
    ebusData = s.data;
    case (s.op)
      OpCono:    conoApr = 1'b1;
      OpConi:    coniApr = 1'b1;
      OpDatai:   dataiApr = 1'b1;
      OpSweep:   sweepBusy = s.data[0];
      OpLoadBlk: loadAcBlocks = 1'b1;
      OpLoadVma: begin
        loadVmaContext = 1'b1;
        vmaPrevEn = s.data[0];
      end
      OpPi: begin
        chkPi = 1'b1;
        expValue = s.expWord;
      end
      OpFm: begin
        fmAdrSel = s.data[2:0];
        xrPrevious = s.data[3];
        chkFm = 1'b1;
        expValue = s.expWord;
      end
      default: ;
    endcase
    @(posedge clk);
    #1;
    conoApr = 1'b0;
    coniApr = 1'b0;
    dataiApr = 1'b0;
    loadAcBlocks = 1'b0;
    loadVmaContext = 1'b0;
    errEvent = '0;
    chkPi = 1'b0;
    chkFm = 1'b0;
    if (s.op == OpConi || s.op == OpDatai) begin
      while (!readValid && waited < ReadTimeout) begin
        @(posedge clk);
        #1;
        waited++;
      end
      if (readValid) begin
        chkRead = 1'b1;
        expValue = s.expWord;
        @(posedge clk);
        #1;
        chkRead = 1'b0;
      end else begin
        timedOut = 1'b1;
        $display("Timeout: readValid did not rise within %0d cycles of a read strobe",
                 ReadTimeout);
      end
    end else if (s.op != OpPi && s.op != OpFm) begin
      // Registered strobes reach the flag cells one edge later
      @(posedge clk);
      #1;
    end
  endtask

  initial begin
    rstN = 1'b0;
    conoApr = 1'b0;
    coniApr = 1'b0;
    dataiApr = 1'b0;
    loadAcBlocks = 1'b0;
    ebusData = '0;
    errEvent = '0;
    sweepBusy = 1'b0;
    ac = 4'hf;
    xr = 4'h9;
    vmaAdr = 4'h5;
    magic = 4'ha;
    magicBlock = 3'd2;
    fmAdrSel = aprPkg::FmAc;
    xrPrevious = 1'b0;
    vmaPrevEn = 1'b0;
    loadVmaContext = 1'b0;
    chkRead = 1'b0;
    chkPi = 1'b0;
    chkFm = 1'b0;
    expValue = '0;
    runDone = 1'b0;
    timedOut = 1'b0;
    buildTable();
    repeat (5) @(posedge clk);
    #1;
    rstN = 1'b1;
    for (int i = 0; i < steps.size() && !timedOut; i++) begin
      applyStep(steps[i]);
    end
    runDone = 1'b1;
    @(posedge clk);
    #1;
    if (!timedOut && failCount == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: sim/aprChecker.sv
`timescale 1ns/10ps
`default_nettype none

module aprChecker (
  input  logic           clk,
  input  aprPkg::aprWord readData,
  input  logic           aprInt,
  input  logic           aprPiReq,
  input  aprPkg::piLevel aprPia,
  input  aprPkg::acAdr   fmAdr,
  input  aprPkg::acBlock fmBlock,
  input  logic           chkRead,
  input  logic           chkPi,
  input  logic           chkFm,
  input  aprPkg::aprWord expValue,
  input  logic           runDone,
  output int             passCount,
  output int             failCount
);

  int   checkNum = 0;
  int   passes = 0;
  int   fails = 0;
  logic reported = 1'b0;

  assign passCount = passes;
  assign failCount = fails;

  task automatic compareValue(input string name, input logic [23:0] expected,
                              input logic [23:0] actual, inout logic bad);
    if (actual !== expected) begin
      $display("FAIL at %0t: %s expected 0x%0h, got 0x%0h", $time, name, expected, actual);
      bad = 1'b1;
    end
  endtask

  always @(posedge clk) begin
    logic bad;
    bad = 1'b0;
    if (chkRead || chkPi || chkFm) begin
      if (chkRead) begin
        compareValue("readData", expValue, readData, bad);
      end
      // Pi layout {int, req, pia}
      if (chkPi) begin
        compareValue("aprInt", 24'(expValue[4]), 24'(aprInt), bad);
        compareValue("aprPiReq", 24'(expValue[3]), 24'(aprPiReq), bad);
        compareValue("aprPia", 24'(expValue[2:0]), 24'(aprPia), bad);
      end
      // Fm layout {block, adr}
      if (chkFm) begin
        compareValue("fmBlock", 24'(expValue[6:4]), 24'(fmBlock), bad);
        compareValue("fmAdr", 24'(expValue[3:0]), 24'(fmAdr), bad);
      end
      checkNum++;
      if (bad) begin
        fails++;
        $display("check %0d mismatch", checkNum);
      end else begin
        passes++;
        $display("check %0d ok", checkNum);
      end
    end
    if (runDone && !reported) begin
      reported = 1'b1;
      $display("Checks: %0d run, %0d passed, %0d failed", checkNum, passes, fails);
    end
  end

endmodule

`default_nettype wire

// File: sim/aprTop_sva.sv
`timescale 1ns/10ps
`default_nettype none

module aprTopSva (
  input logic           clk,
  input logic           rstN,
  input logic           conoApr,
  input aprPkg::aprWord ebusData,
  input logic           sweepBusy,
  input logic           coniApr,
  input logic           readValid,
  input logic           aprPiReq,
  input aprPkg::piLevel aprPia,
  input aprPkg::aprWord readData
);

  logic           busyQ;
  logic           fallQ;
  logic           sweepDue;
  logic           piaLoadQ;
  aprPkg::piLevel piaNext;
  aprPkg::piLevel piaModel;

  // Flag 7 is in place two edges after the fall
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      busyQ    <= 1'b0;
      fallQ    <= 1'b0;
      sweepDue <= 1'b0;
    end else begin
      busyQ <= sweepBusy;
      fallQ <= busyQ & ~sweepBusy;
      if (fallQ) begin
        sweepDue <= 1'b1;
      end else if (coniApr) begin
        sweepDue <= 1'b0;
      end
    end
  end

  // PI level as loaded by CONO, two edges after the command
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      piaLoadQ <= 1'b0;
      piaNext  <= '0;
      piaModel <= '0;
    end else begin
      piaLoadQ <= conoApr & ebusData[aprPkg::LoadPiaBit];
      piaNext  <= ebusData[aprPkg::PiaLsb +: $bits(aprPkg::piLevel)];
      if (piaLoadQ) begin
        piaModel <= piaNext;
      end
    end
  end

  singleValid: assert property (@(posedge clk) disable iff (!rstN)
    readValid |=> !readValid)
    else $error("readValid high for two cycles in a row");

  reqNeedsLevel: assert property (@(posedge clk) disable iff (!rstN)
    aprPiReq |-> ((aprPia != '0) && (aprPia == piaModel)))
    else $error("aprPiReq high without a nonzero PI level loaded by CONO");

  sweepReadBack: assert property (@(posedge clk) disable iff (!rstN)
    coniApr && sweepDue |=> readData[aprPkg::FlagSweepDone])
    else $error("CONI after a sweep fall did not show the sweep done flag");

endmodule

bind aprTop aprTopSva uSva (
  .clk       (clk),
  .rstN      (rstN),
  .conoApr   (conoApr),
  .ebusData  (ebusData),
  .sweepBusy (sweepBusy),
  .coniApr   (coniApr),
  .readValid (readValid),
  .aprPiReq  (aprPiReq),
  .aprPia    (aprPia),
  .readData  (readData)
);

`default_nettype wire

// File: src/aprTop.sv
`timescale 1ns/10ps
`default_nettype none

module aprTop (
  input  logic                             clk,
  input  logic                             rstN,
  input  logic                             conoApr,
  input  logic                             coniApr,
  input  logic                             dataiApr,
  input  logic                             loadAcBlocks,
  input  aprPkg::aprWord                   ebusData,
  input  logic [aprPkg::FlagSweepDone-1:0] errEvent,
  input  logic                             sweepBusy,
  input  aprPkg::acAdr                     ac,
  input  aprPkg::acAdr                     xr,
  input  aprPkg::acAdr                     vmaAdr,
  input  aprPkg::acAdr                     magic,
  input  aprPkg::acBlock                   magicBlock,
  input  aprPkg::fmSel                     fmAdrSel,
  input  logic                             xrPrevious,
  input  logic                             vmaPrevEn,
  input  logic                             loadVmaContext,
  output logic                             aprInt,
  output logic                             aprPiReq,
  output aprPkg::piLevel                   aprPia,
  output aprPkg::aprWord                   readData,
  output logic                             readValid,
  output aprPkg::acAdr                     fmAdr,
  output aprPkg::acBlock                   fmBlock
);

  aprPkg::flagVec setFlag;
  aprPkg::flagVec clrFlag;
  aprPkg::flagVec enFlag;
  aprPkg::flagVec disFlag;
  aprPkg::flagVec evt;
  aprPkg::flagVec flags;
  aprPkg::flagVec enables;
  logic           piaLoad;
  aprPkg::piLevel piaValue;
  aprPkg::acBlock currentBlock;
  aprPkg::acBlock prevBlock;
  aprPkg::acBlock vmaBlock;

  aprCmdDecode uDecode (
    .clk, .rstN, .conoApr, .ebusData, .errEvent, .sweepBusy,
    .setFlag, .clrFlag, .enFlag, .disFlag, .evt, .piaLoad, .piaValue
  );

  for (genvar i = 0; i < aprPkg::NumFlags; i++) begin : gFlag
    aprFlagCell uCell (
      .clk     (clk),
      .rstN    (rstN),
      .setFlag (setFlag[i]),
      .clrFlag (clrFlag[i]),
      .enFlag  (enFlag[i]),
      .disFlag (disFlag[i]),
      .evt     (evt[i]),
      .flag    (flags[i]),
      .intEn   (enables[i])
    );
  end

  aprStatusUnit uStatus (
    .clk, .rstN, .flags, .enables, .piaLoad, .piaValue, .coniApr, .dataiApr,
    .currentBlock, .prevBlock, .vmaBlock,
    .aprInt, .aprPiReq, .aprPia, .readData, .readValid
  );

  fmAdrSelect uFmAdr (
    .clk, .rstN, .ebusData, .loadAcBlocks, .loadVmaContext, .vmaPrevEn, .xrPrevious,
    .ac, .xr, .vmaAdr, .magic, .magicBlock, .fmAdrSel,
    .fmAdr, .fmBlock, .currentBlock, .prevBlock, .vmaBlock
  );

endmodule

`default_nettype wire

// File: src/fmAdrSelect.sv
`timescale 1ns/10ps
`default_nettype none

module fmAdrSelect (
  input  logic           clk,
  input  logic           rstN,
  input  aprPkg::aprWord ebusData,
  input  logic           loadAcBlocks,
  input  logic           loadVmaContext,
  input  logic           vmaPrevEn,
  input  logic           xrPrevious,
  input  aprPkg::acAdr   ac,
  input  aprPkg::acAdr   xr,
  input  aprPkg::acAdr   vmaAdr,
  input  aprPkg::acAdr   magic,
  input  aprPkg::acBlock magicBlock,
  input  aprPkg::fmSel   fmAdrSel,
  output aprPkg::acAdr   fmAdr,
  output aprPkg::acBlock fmBlock,
  output aprPkg::acBlock currentBlock,
  output aprPkg::acBlock prevBlock,
  output aprPkg::acBlock vmaBlock
);

  aprPkg::acAdr   acPlus1;
  aprPkg::acAdr   acPlus2;
  aprPkg::acAdr   acPlus3;
  aprPkg::acAdr   acPlusMagic;
  aprPkg::acBlock xrBlock;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      currentBlock <= '0;
      prevBlock    <= '0;
    end else if (loadAcBlocks) begin
      currentBlock <= ebusData[aprPkg::DataiCurLsb +: $bits(aprPkg::acBlock)];
      prevBlock    <= ebusData[aprPkg::DataiPrevLsb +: $bits(aprPkg::acBlock)];
    end
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      vmaBlock <= '0;
    end else if (loadVmaContext) begin
      vmaBlock <= vmaPrevEn ? prevBlock : currentBlock;
    end
  end

  // AC arithmetic wraps within the 16-word block
  assign acPlus1     = ac + 4'd1;
  assign acPlus2     = ac + 4'd2;
  assign acPlus3     = ac + 4'd3;
  assign acPlusMagic = ac + magic;

  assign xrBlock = xrPrevious ? prevBlock : currentBlock;

  always_comb begin
    unique case (fmAdrSel)
      aprPkg::FmAc:          fmAdr = ac;
      aprPkg::FmAcPlus1:     fmAdr = acPlus1;
      aprPkg::FmXr:          fmAdr = xr;
      aprPkg::FmVma:         fmAdr = vmaAdr;
      aprPkg::FmAcPlus2:     fmAdr = acPlus2;
      aprPkg::FmAcPlus3:     fmAdr = acPlus3;
      aprPkg::FmAcPlusMagic: fmAdr = acPlusMagic;
      aprPkg::FmMagic:       fmAdr = magic;
    endcase
  end

  always_comb begin
    case (fmAdrSel)
      aprPkg::FmXr:    fmBlock = xrBlock;
      aprPkg::FmVma:   fmBlock = vmaBlock;
      aprPkg::FmMagic: fmBlock = magicBlock;
      default:         fmBlock = currentBlock;
    endcase
  end

endmodule

`default_nettype wire

// File: src/aprStatusUnit.sv
`timescale 1ns/10ps
`default_nettype none

module aprStatusUnit (
  input  logic           clk,
  input  logic           rstN,
  input  aprPkg::flagVec flags,
  input  aprPkg::flagVec enables,
  input  logic           piaLoad,
  input  aprPkg::piLevel piaValue,
  input  logic           coniApr,
  input  logic           dataiApr,
  input  aprPkg::acBlock currentBlock,
  input  aprPkg::acBlock prevBlock,
  input  aprPkg::acBlock vmaBlock,
  output logic           aprInt,
  output logic           aprPiReq,
  output aprPkg::piLevel aprPia,
  output aprPkg::aprWord readData,
  output logic           readValid
);

  aprPkg::aprWord coniWord;
  aprPkg::aprWord dataiWord;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      aprPia <= '0;
    end else if (piaLoad) begin
      aprPia <= piaValue;
    end
  end

  assign aprInt = |(flags & enables);

  // PI level 0 means no interrupt channel
  assign aprPiReq = aprInt & (aprPia != '0);

  always_comb begin
    coniWord = '0;
    coniWord[aprPkg::ConiFlagLsb +: aprPkg::NumFlags] = flags;
    coniWord[aprPkg::ConiEnLsb +: aprPkg::NumFlags] = enables;
    coniWord[aprPkg::ConiPiaLsb +: $bits(aprPkg::piLevel)] = aprPia;
    coniWord[aprPkg::ConiIntBit] = aprInt;
  end

  always_comb begin
    dataiWord = '0;
    dataiWord[aprPkg::DataiCurLsb +: $bits(aprPkg::acBlock)] = currentBlock;
    dataiWord[aprPkg::DataiPrevLsb +: $bits(aprPkg::acBlock)] = prevBlock;
    dataiWord[aprPkg::DataiVmaLsb +: $bits(aprPkg::acBlock)] = vmaBlock;
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      readValid <= 1'b0;
    end else begin
      readValid <= coniApr | dataiApr;
    end
  end

  // CONI first when both strobes arrive
  always_ff @(posedge clk) begin
    if (coniApr) begin
      readData <= coniWord;
    end else if (dataiApr) begin
      readData <= dataiWord;
    end
  end

endmodule

`default_nettype wire

// File: src/aprFlagCell.sv
`timescale 1ns/10ps
`default_nettype none

module aprFlagCell (
  input  logic clk,
  input  logic rstN,
  input  logic setFlag,
  input  logic clrFlag,
  input  logic enFlag,
  input  logic disFlag,
  input  logic evt,
  output logic flag,
  output logic intEn
);

  // Event wins over a clear in the same cycle
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      flag <= 1'b0;
    end else if (evt || setFlag) begin
      flag <= 1'b1;
    end else if (clrFlag) begin
      flag <= 1'b0;
    end
  end

  // Enable wins over disable
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      intEn <= 1'b0;
    end else if (enFlag) begin
      intEn <= 1'b1;
    end else if (disFlag) begin
      intEn <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: src/aprCmdDecode.sv
`timescale 1ns/10ps
`default_nettype none

module aprCmdDecode (
  input  logic                                 clk,
  input  logic                                 rstN,
  input  logic                                 conoApr,
  input  aprPkg::aprWord                       ebusData,
  input  logic [aprPkg::FlagSweepDone-1:0]     errEvent,
  input  logic                                 sweepBusy,
  output aprPkg::flagVec                       setFlag,
  output aprPkg::flagVec                       clrFlag,
  output aprPkg::flagVec                       enFlag,
  output aprPkg::flagVec                       disFlag,
  output aprPkg::flagVec                       evt,
  output logic                                 piaLoad,
  output aprPkg::piLevel                       piaValue
);

  aprPkg::flagVec mask;
  aprPkg::flagVec evtNext;
  logic           sweepPrev;
  logic           sweepFall;
  logic           selSet;
  logic           selClr;
  logic           selEn;
  logic           selDis;

  assign mask   = ebusData[aprPkg::MaskLsb +: aprPkg::NumFlags];
  assign selSet = conoApr & ebusData[aprPkg::SelSetBit];
  assign selClr = conoApr & ebusData[aprPkg::SelClrBit];
  assign selEn  = conoApr & ebusData[aprPkg::SelEnBit];
  assign selDis = conoApr & ebusData[aprPkg::SelDisBit];

  // Sweep done is the end of a busy period
  assign sweepFall = sweepPrev & ~sweepBusy;

  always_comb begin
    evtNext[aprPkg::FlagSbusErr]    = errEvent[aprPkg::FlagSbusErr];
    evtNext[aprPkg::FlagNxmErr]     = errEvent[aprPkg::FlagNxmErr];
    evtNext[aprPkg::FlagIoPfErr]    = errEvent[aprPkg::FlagIoPfErr];
    evtNext[aprPkg::FlagMbParErr]   = errEvent[aprPkg::FlagMbParErr];
    evtNext[aprPkg::FlagCdirParErr] = errEvent[aprPkg::FlagCdirParErr];
    evtNext[aprPkg::FlagSadrParErr] = errEvent[aprPkg::FlagSadrParErr];
    evtNext[aprPkg::FlagPwrFail]    = errEvent[aprPkg::FlagPwrFail];
    evtNext[aprPkg::FlagSweepDone]  = sweepFall;
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      setFlag   <= '0;
      clrFlag   <= '0;
      enFlag    <= '0;
      disFlag   <= '0;
      evt       <= '0;
      piaLoad   <= 1'b0;
      sweepPrev <= 1'b0;
    end else begin
      // Strobes last one cycle, only after a CONO
      setFlag   <= {aprPkg::NumFlags{selSet}} & mask;
      clrFlag   <= {aprPkg::NumFlags{selClr}} & mask;
      enFlag    <= {aprPkg::NumFlags{selEn}} & mask;
      disFlag   <= {aprPkg::NumFlags{selDis}} & mask;
      evt       <= evtNext;
      piaLoad   <= conoApr & ebusData[aprPkg::LoadPiaBit];
      sweepPrev <= sweepBusy;
    end
  end

  // Qualified by piaLoad downstream
  always_ff @(posedge clk) begin
    if (conoApr) begin
      piaValue <= ebusData[aprPkg::PiaLsb +: $bits(aprPkg::piLevel)];
    end
  end

endmodule

`default_nettype wire

// File: src/aprPkg.sv
`default_nettype none

package aprPkg;

  // Word and field types
  typedef logic [23:0] aprWord;
  typedef logic [7:0]  flagVec;
  typedef logic [2:0]  piLevel;
  typedef logic [3:0]  acAdr;
  typedef logic [2:0]  acBlock;
  typedef logic [2:0]  fmSel;

  localparam int NumFlags = 8;

  // CONO command word
  localparam int MaskLsb    = 0;
  localparam int SelClrBit  = 8;
  localparam int SelSetBit  = 9;
  localparam int SelDisBit  = 10;
  localparam int SelEnBit   = 11;
  localparam int LoadPiaBit = 12;
  localparam int PiaLsb     = 13;

  // CONI read word
  localparam int ConiFlagLsb = 0;
  localparam int ConiEnLsb   = 8;
  localparam int ConiPiaLsb  = 16;
  localparam int ConiIntBit  = 19;

  // DATAI read word, also the block-load layout
  localparam int DataiCurLsb  = 0;
  localparam int DataiPrevLsb = 3;
  localparam int DataiVmaLsb  = 6;

  // Flag positions
  localparam int FlagSbusErr    = 0;
  localparam int FlagNxmErr     = 1;
  localparam int FlagIoPfErr    = 2;
  localparam int FlagMbParErr   = 3;
  localparam int FlagCdirParErr = 4;
  localparam int FlagSadrParErr = 5;
  localparam int FlagPwrFail    = 6;
  localparam int FlagSweepDone  = 7;

  // Microcode fast-memory address select
  localparam fmSel FmAc          = 3'd0;
  localparam fmSel FmAcPlus1     = 3'd1;
  localparam fmSel FmXr          = 3'd2;
  localparam fmSel FmVma         = 3'd3;
  localparam fmSel FmAcPlus2     = 3'd4;
  localparam fmSel FmAcPlus3     = 3'd5;
  localparam fmSel FmAcPlusMagic = 3'd6;
  localparam fmSel FmMagic       = 3'd7;

endpackage

`default_nettype wire
